// File: hdl/rate_pkg.sv
package rate_pkg;

    // PCIe generation as seen on the PIPE rate input
    typedef enum logic [1:0]
    {
        GEN1 = 2'd0,
        GEN2 = 2'd1,
        GEN3 = 2'd2
    } gen_e;

    // PLL that serves Gen1/Gen2; Gen3 always runs from the QPLL
    typedef enum bit
    {
        CPLL = 1'b0,
        QPLL = 1'b1
    } pll_sel_e;

    typedef enum logic [4:0]
    {
        IDLE,
        PLL_PU,                // Gen3 entry or exit only
        PLL_PURESET,
        PLL_LOCK,
        DRP_X16_GEN3_START,
        DRP_X16_GEN3_DONE,
        PMARESET_HOLD,
        PLL_SEL,
        MMCM_LOCK,
        DRP_START,
        DRP_DONE,
        PMARESET_RELEASE,
        PMARESET_DONE,
        TXDATA_WAIT,           // Common ending starts here
        PCLK_SEL,
        RATE_SEL,
        RATE_DONE,
        PLL_PDRESET,
        PLL_PD,
        TXSYNC_START,
        TXSYNC_DONE,
        DONE
    } state_e;

    localparam int RATE_OUT_W  = 3;   // TX/RX rate code width
    localparam int SYSCLKSEL_W = 2;

    typedef logic [3:0] wait_cnt_t;

endpackage

// File: hdl/rate_input_sync.sv
module rate_input_sync
(
    input  logic           RATE_CLK,
    input  logic           RATE_RST_N,
    input  logic           rst_idle,
    input  rate_pkg::gen_e rate_in,
    input  logic           cplllock,
    input  logic           qplllock,
    input  logic           mmcm_lock,
    input  logic           drp_done,
    input  logic           txresetdone,
    input  logic           rxresetdone,
    input  logic           txratedone,
    input  logic           rxratedone,
    input  logic           phystatus,
    input  logic           txsync_done,
    input  logic           rxpmaresetdone,
    output logic           rst_idle_s,
    output rate_pkg::gen_e rate_cur,
    output rate_pkg::gen_e rate_next,
    output logic           rate_change,
    output logic           cplllock_s,
    output logic           qplllock_s,
    output logic           mmcm_lock_s,
    output logic           drp_done_s,
    output logic           txresetdone_s,
    output logic           rxresetdone_s,
    output logic           txratedone_s,
    output logic           rxratedone_s,
    output logic           phystatus_s,
    output logic           txsync_done_s,
    output logic           rxpmaresetdone_s
);
    localparam int NUM_STATUS = 12;

    logic [NUM_STATUS-1:0] status_in;
    logic [NUM_STATUS-1:0] status_s1;   // Metastability stage
    logic [NUM_STATUS-1:0] status_s2;

    assign status_in = {rst_idle, cplllock, qplllock, mmcm_lock, drp_done, txresetdone,
                        rxresetdone, txratedone, rxratedone, phystatus, txsync_done,
                        rxpmaresetdone};

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            status_s1 <= '0;
            status_s2 <= '0;
            rate_next <= rate_pkg::GEN1;
            rate_cur  <= rate_pkg::GEN1;
        end
        else
        begin
            status_s1 <= status_in;
            status_s2 <= status_s1;
            rate_next <= rate_in;
            rate_cur  <= rate_next;
        end
    end

    assign {rst_idle_s, cplllock_s, qplllock_s, mmcm_lock_s, drp_done_s, txresetdone_s,
            rxresetdone_s, txratedone_s, rxratedone_s, phystatus_s, txsync_done_s,
            rxpmaresetdone_s} = status_s2;

    // One-cycle strobe while the two rate stages disagree
    assign rate_change = (rate_next != rate_cur);

endmodule

// File: hdl/rate_done_tracker.sv
module rate_done_tracker
(
    input  logic RATE_CLK,
    input  logic RATE_RST_N,
    input  logic collect,
    input  logic txratedone_s,
    input  logic rxratedone_s,
    input  logic phystatus_s,
    output logic all_done
);
    logic tx_seen;
    logic rx_seen;
    logic phy_seen;

    // Events may arrive in any order and need not overlap
    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N || !collect)
        begin
            tx_seen  <= 1'b0;
            rx_seen  <= 1'b0;
            phy_seen <= 1'b0;
            all_done <= 1'b0;
        end
        else
        begin
            tx_seen  <= tx_seen  | txratedone_s;
            rx_seen  <= rx_seen  | rxratedone_s;
            phy_seen <= phy_seen | phystatus_s;
            all_done <= tx_seen & rx_seen & phy_seen;
        end
    end

    // A new collect window never starts with a stale result
    a_no_stale_done: assert property (@(posedge RATE_CLK) disable iff (!RATE_RST_N)
        !collect |=> !all_done);

endmodule

// File: hdl/rate_sequencer.sv
module rate_sequencer
#(
    parameter rate_pkg::pll_sel_e  PLL_SEL         = rate_pkg::CPLL,
    parameter rate_pkg::wait_cnt_t TXDATA_WAIT_MAX = 4'd15
)
(
    input  logic                             RATE_CLK,
    input  logic                             RATE_RST_N,
    input  logic                             active_lane,
    input  logic                             rst_idle_s,
    input  rate_pkg::gen_e                   rate_cur,
    input  rate_pkg::gen_e                   rate_next,
    input  logic                             rate_change,
    input  logic                             cplllock_s,
    input  logic                             qplllock_s,
    input  logic                             mmcm_lock_s,
    input  logic                             drp_done_s,
    input  logic                             txresetdone_s,
    input  logic                             rxresetdone_s,
    input  logic                             phystatus_s,
    input  logic                             txsync_done_s,
    input  logic                             rxpmaresetdone_s,
    input  logic                             all_done,
    output logic                             collect,
    output logic                             cpllpd,
    output logic                             qpllpd,
    output logic                             cpllreset,
    output logic                             qpllreset,
    output logic                             txpmareset,
    output logic                             rxpmareset,
    output logic                             drp_start,
    output logic [rate_pkg::SYSCLKSEL_W-1:0] sysclksel,
    output logic                             pclk_sel,
    output logic                             gen3,
    output logic [rate_pkg::RATE_OUT_W-1:0]  rate_out,
    output logic                             txsync_start,
    output logic                             done,
    output logic                             idle
);
    localparam logic [rate_pkg::SYSCLKSEL_W-1:0] SYSCLK_CPLL = '0;
    localparam logic [rate_pkg::SYSCLKSEL_W-1:0] SYSCLK_QPLL = 1;
    localparam logic [rate_pkg::RATE_OUT_W-1:0]  RATE_GEN2   =
        (PLL_SEL == rate_pkg::QPLL) ? 2 : 1;   // Divide by 2 on QPLL, by 1 on CPLL
    localparam bit USE_QPLL = (PLL_SEL == rate_pkg::QPLL);

    rate_pkg::state_e                    state;
    rate_pkg::wait_cnt_t                 wait_cnt;
    logic                                gen3_exit;
    logic                                is_gen3;
    logic                                pll_lock;
    logic [rate_pkg::RATE_OUT_W-1:0]     rate_code;

    assign is_gen3   = (rate_cur == rate_pkg::GEN3);
    assign pll_lock  = (is_gen3 || USE_QPLL) ? qplllock_s : cplllock_s;
    assign rate_code = (rate_cur == rate_pkg::GEN2) ? RATE_GEN2 : '0;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N || (state != rate_pkg::TXDATA_WAIT))
            wait_cnt <= '0;
        else if (wait_cnt != TXDATA_WAIT_MAX)
            wait_cnt <= wait_cnt + 1'b1;
    end

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            state      <= rate_pkg::PLL_LOCK;   // Runs the reset sequence first
            gen3_exit  <= 1'b0;
            cpllpd     <= 1'b0;
            qpllpd     <= 1'b0;
            cpllreset  <= 1'b0;
            qpllreset  <= 1'b0;
            txpmareset <= 1'b0;
            rxpmareset <= 1'b0;
            drp_start  <= 1'b0;
            sysclksel  <= USE_QPLL ? SYSCLK_QPLL : SYSCLK_CPLL;
            pclk_sel   <= 1'b0;
            gen3       <= 1'b0;
            rate_out   <= '0;
        end
        else
        begin
            drp_start <= 1'b0;
            case (state)
                rate_pkg::IDLE:
                    if (rate_change)
                    begin
                        gen3_exit <= is_gen3;
                        if (is_gen3 || (rate_next == rate_pkg::GEN3))
                            state <= rate_pkg::PLL_PU;
                        else
                            state <= rate_pkg::TXDATA_WAIT;
                    end
                rate_pkg::PLL_PU:
                begin
                    cpllpd <= USE_QPLL;
                    qpllpd <= 1'b0;
                    state  <= rate_pkg::PLL_PURESET;
                end
                rate_pkg::PLL_PURESET:
                begin
                    cpllreset <= USE_QPLL;
                    qpllreset <= 1'b0;
                    state     <= rate_pkg::PLL_LOCK;
                end
                rate_pkg::PLL_LOCK:
                    if (pll_lock)
                        state <= (rst_idle_s && is_gen3) ? rate_pkg::DRP_X16_GEN3_START
                                                         : rate_pkg::PMARESET_HOLD;
                rate_pkg::DRP_X16_GEN3_START:
                begin
                    drp_start <= 1'b1;
                    if (!drp_done_s)
                        state <= rate_pkg::DRP_X16_GEN3_DONE;
                end
                rate_pkg::DRP_X16_GEN3_DONE:
                    if (drp_done_s)
                        state <= rate_pkg::PMARESET_HOLD;
                rate_pkg::PMARESET_HOLD:
                begin
                    txpmareset <= is_gen3 || gen3_exit;
                    rxpmareset <= is_gen3 || gen3_exit;
                    state      <= rate_pkg::PLL_SEL;
                end
                rate_pkg::PLL_SEL:
                begin
                    sysclksel <= (is_gen3 || USE_QPLL) ? SYSCLK_QPLL : SYSCLK_CPLL;
                    state     <= rate_pkg::MMCM_LOCK;
                end
                rate_pkg::MMCM_LOCK:
                    if (mmcm_lock_s && !rxpmaresetdone_s)
                        state <= rate_pkg::DRP_START;
                rate_pkg::DRP_START:
                begin
                    drp_start <= 1'b1;
                    pclk_sel  <= (rate_cur != rate_pkg::GEN1);
                    gen3      <= is_gen3;
                    if (is_gen3 || gen3_exit)
                        rate_out <= rate_code;
                    if (!drp_done_s)
                        state <= rate_pkg::DRP_DONE;
                end
                rate_pkg::DRP_DONE:
                    if (drp_done_s && pll_lock)
                        state <= rst_idle_s ? rate_pkg::PMARESET_RELEASE : rate_pkg::DONE;
                rate_pkg::PMARESET_RELEASE:
                begin
                    txpmareset <= 1'b0;
                    rxpmareset <= 1'b0;
                    state      <= rate_pkg::PMARESET_DONE;
                end
                rate_pkg::PMARESET_DONE:
                    if ((txresetdone_s && rxresetdone_s && !phystatus_s) || !active_lane)
                        state <= rate_pkg::TXDATA_WAIT;
                rate_pkg::TXDATA_WAIT:
                    if (wait_cnt == TXDATA_WAIT_MAX)
                        state <= rate_pkg::PCLK_SEL;
                rate_pkg::PCLK_SEL:
                begin
                    pclk_sel <= (rate_cur != rate_pkg::GEN1);   // 250 MHz for Gen2/Gen3
                    state    <= rate_pkg::RATE_SEL;
                end
                rate_pkg::RATE_SEL:
                begin
                    rate_out <= rate_code;
                    state    <= rate_pkg::RATE_DONE;
                end
                rate_pkg::RATE_DONE:
                    if (all_done || is_gen3 || gen3_exit || !active_lane)
                        state <= rate_pkg::PLL_PDRESET;
                rate_pkg::PLL_PDRESET:
                begin
                    cpllreset <= USE_QPLL || is_gen3;
                    qpllreset <= !USE_QPLL && !is_gen3;
                    state     <= rate_pkg::PLL_PD;
                end
                rate_pkg::PLL_PD:
                begin
                    cpllpd <= USE_QPLL || is_gen3;
                    qpllpd <= !USE_QPLL && !is_gen3;
                    state  <= rate_pkg::TXSYNC_START;
                end
                rate_pkg::TXSYNC_START:
                    if (!txsync_done_s)
                        state <= rate_pkg::TXSYNC_DONE;
                rate_pkg::TXSYNC_DONE:
                    if (txsync_done_s)
                        state <= rate_pkg::DONE;
                default:
                    state <= rate_pkg::IDLE;   // DONE and any stray encoding
            endcase
        end
    end

    assign collect      = (state == rate_pkg::RATE_DONE);
    assign txsync_start = (state == rate_pkg::TXSYNC_START);
    assign done         = (state == rate_pkg::DONE);
    assign idle         = (state == rate_pkg::IDLE);

    a_done_then_idle: assert property (@(posedge RATE_CLK) disable iff (!RATE_RST_N)
        done |-> !idle ##1 (idle && !done));

    // Every DRP request is closed out before the sequencer rests
    a_no_drp_in_idle: assert property (@(posedge RATE_CLK) disable iff (!RATE_RST_N)
        idle |-> !drp_start);

endmodule

// File: hdl/pipe_rate.sv
module pipe_rate
#(
    parameter rate_pkg::pll_sel_e  PLL_SEL         = rate_pkg::CPLL,
    parameter bit                  POWER_SAVING    = 1'b1,
    parameter rate_pkg::wait_cnt_t TXDATA_WAIT_MAX = 4'd15
)
(
    input  logic                             RATE_CLK,
    input  logic                             RATE_RST_N,
    input  logic                             rst_idle,
    input  logic                             active_lane,
    input  rate_pkg::gen_e                   rate_in,
    input  logic                             cplllock,
    input  logic                             qplllock,
    input  logic                             mmcm_lock,
    input  logic                             drp_done,
    input  logic                             rxpmaresetdone,
    input  logic                             txresetdone,
    input  logic                             rxresetdone,
    input  logic                             txratedone,
    input  logic                             rxratedone,
    input  logic                             phystatus,
    input  logic                             txsync_done,
    output logic                             cpllpd,
    output logic                             qpllpd,
    output logic                             cpllreset,
    output logic                             qpllreset,
    output logic                             txpmareset,
    output logic                             rxpmareset,
    output logic                             drp_start,
    output logic [rate_pkg::SYSCLKSEL_W-1:0] sysclksel,
    output logic                             pclk_sel,
    output logic                             gen3,
    output logic [rate_pkg::RATE_OUT_W-1:0]  rate_out,
    output logic                             txsync_start,
    output logic                             done,
    output logic                             idle
);
    rate_pkg::gen_e rate_cur;
    rate_pkg::gen_e rate_next;
    logic           rst_idle_s;
    logic           rate_change;
    logic           cplllock_s;
    logic           qplllock_s;
    logic           mmcm_lock_s;
    logic           drp_done_s;
    logic           txresetdone_s;
    logic           rxresetdone_s;
    logic           txratedone_s;
    logic           rxratedone_s;
    logic           phystatus_s;
    logic           txsync_done_s;
    logic           rxpmaresetdone_s;
    logic           collect;
    logic           all_done;
    logic           seq_cpllpd;
    logic           seq_qpllpd;
    logic           seq_cpllreset;
    logic           seq_qpllreset;

    rate_input_sync u_sync
    (
        .RATE_CLK         (RATE_CLK),
        .RATE_RST_N       (RATE_RST_N),
        .rst_idle         (rst_idle),
        .rate_in          (rate_in),
        .cplllock         (cplllock),
        .qplllock         (qplllock),
        .mmcm_lock        (mmcm_lock),
        .drp_done         (drp_done),
        .txresetdone      (txresetdone),
        .rxresetdone      (rxresetdone),
        .txratedone       (txratedone),
        .rxratedone       (rxratedone),
        .phystatus        (phystatus),
        .txsync_done      (txsync_done),
        .rxpmaresetdone   (rxpmaresetdone),
        .rst_idle_s       (rst_idle_s),
        .rate_cur         (rate_cur),
        .rate_next        (rate_next),
        .rate_change      (rate_change),
        .cplllock_s       (cplllock_s),
        .qplllock_s       (qplllock_s),
        .mmcm_lock_s      (mmcm_lock_s),
        .drp_done_s       (drp_done_s),
        .txresetdone_s    (txresetdone_s),
        .rxresetdone_s    (rxresetdone_s),
        .txratedone_s     (txratedone_s),
        .rxratedone_s     (rxratedone_s),
        .phystatus_s      (phystatus_s),
        .txsync_done_s    (txsync_done_s),
        .rxpmaresetdone_s (rxpmaresetdone_s)
    );

    rate_done_tracker u_done
    (
        .RATE_CLK     (RATE_CLK),
        .RATE_RST_N   (RATE_RST_N),
        .collect      (collect),
        .txratedone_s (txratedone_s),
        .rxratedone_s (rxratedone_s),
        .phystatus_s  (phystatus_s),
        .all_done     (all_done)
    );

    rate_sequencer #(
        .PLL_SEL         (PLL_SEL),
        .TXDATA_WAIT_MAX (TXDATA_WAIT_MAX)
    ) u_seq (
        .RATE_CLK         (RATE_CLK),
        .RATE_RST_N       (RATE_RST_N),
        .active_lane      (active_lane),
        .rst_idle_s       (rst_idle_s),
        .rate_cur         (rate_cur),
        .rate_next        (rate_next),
        .rate_change      (rate_change),
        .cplllock_s       (cplllock_s),
        .qplllock_s       (qplllock_s),
        .mmcm_lock_s      (mmcm_lock_s),
        .drp_done_s       (drp_done_s),
        .txresetdone_s    (txresetdone_s),
        .rxresetdone_s    (rxresetdone_s),
        .phystatus_s      (phystatus_s),
        .txsync_done_s    (txsync_done_s),
        .rxpmaresetdone_s (rxpmaresetdone_s),
        .all_done         (all_done),
        .collect          (collect),
        .cpllpd           (seq_cpllpd),
        .qpllpd           (seq_qpllpd),
        .cpllreset        (seq_cpllreset),
        .qpllreset        (seq_qpllreset),
        .txpmareset       (txpmareset),
        .rxpmareset       (rxpmareset),
        .drp_start        (drp_start),
        .sysclksel        (sysclksel),
        .pclk_sel         (pclk_sel),
        .gen3             (gen3),
        .rate_out         (rate_out),
        .txsync_start     (txsync_start),
        .done             (done),
        .idle             (idle)
    );

    // Without power saving both PLLs stay up and out of reset
    assign cpllpd    = POWER_SAVING ? seq_cpllpd    : 1'b0;
    assign qpllpd    = POWER_SAVING ? seq_qpllpd    : 1'b0;
    assign cpllreset = POWER_SAVING ? seq_cpllreset : 1'b0;
    assign qpllreset = POWER_SAVING ? seq_qpllreset : 1'b0;

endmodule

// File: tests/tb_pipe_rate.sv
module tb_pipe_rate;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int DONE_BOUND   = 400;
    localparam int QUIET_CYCLES = 100;
    localparam int NUM_TESTS    = 6;
    // Two bounded waits per test plus the quiet window of the collection test
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * 2 * DONE_BOUND + QUIET_CYCLES;

    logic           RATE_CLK = 1'b0;
    logic           RATE_RST_N;
    logic           rst_idle;
    logic           active_lane;
    rate_pkg::gen_e rate_in;
    logic           cplllock;
    logic           qplllock;
    logic           mmcm_lock;
    logic           drp_done = 1'b1;
    logic           rxpmaresetdone;
    logic           txresetdone = 1'b1;
    logic           rxresetdone = 1'b1;
    logic           txratedone;
    logic           rxratedone;
    logic           phystatus;
    logic           txsync_done = 1'b1;
    logic           cpllpd;
    logic           qpllpd;
    logic           cpllreset;
    logic           qpllreset;
    logic           txpmareset;
    logic           rxpmareset;
    logic           drp_start;
    logic [1:0]     sysclksel;
    logic           pclk_sel;
    logic           gen3;
    logic [2:0]     rate_out;
    logic           txsync_start;
    logic           done;
    logic           idle;

    int errors = 0;
    int checks = 0;
    bit pma_tx_seen;
    bit pma_rx_seen;

    pipe_rate #(
        .PLL_SEL         (rate_pkg::CPLL),
        .POWER_SAVING    (1'b1),
        .TXDATA_WAIT_MAX (4'd15)
    ) i_dut (.*);

    always #(CLK_PERIOD / 2) RATE_CLK = ~RATE_CLK;

    // DRP port of the PHY answers drp_start
    initial
    begin
        forever
        begin
            @(posedge RATE_CLK);
            if (drp_start)
            begin
                drp_done <= 1'b0;
                @(posedge RATE_CLK);
                while (drp_start)
                    @(posedge RATE_CLK);
                repeat ($urandom_range(8, 2)) @(posedge RATE_CLK);
                drp_done <= 1'b1;
            end
        end
    end

    initial
    begin
        forever
        begin
            @(posedge RATE_CLK);
            if (txsync_start)
            begin
                txsync_done <= 1'b0;   // Phase alignment in progress
                @(posedge RATE_CLK);
                while (txsync_start)
                    @(posedge RATE_CLK);
                repeat ($urandom_range(8, 2)) @(posedge RATE_CLK);
                txsync_done <= 1'b1;
            end
        end
    end

    // Reset done follows the PMA reset one cycle later
    always @(posedge RATE_CLK)
    begin
        txresetdone <= !txpmareset;
        rxresetdone <= !rxpmareset;
    end

    task automatic check_value(input string test_name, input string what,
                               input int expected, input int actual);
        checks++;
        assert (expected == actual)
        else
        begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic check_true(input string test_name, input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    task automatic sample_cycle();
        @(negedge RATE_CLK);
        if (txpmareset)
            pma_tx_seen = 1'b1;
        if (rxpmareset)
            pma_rx_seen = 1'b1;
    endtask

    task automatic wait_done(input string test_name);
        int cycles;
        cycles = 0;
        do
        begin
            sample_cycle();
            cycles++;
        end
        while (!done && cycles < DONE_BOUND);
        check_true(test_name, done, "done did not arrive within the bound");
    endtask

    task automatic wait_rate_out(input string test_name, input int value);
        int cycles;
        cycles = 0;
        while (int'(rate_out) != value && cycles < DONE_BOUND)
        begin
            sample_cycle();
            cycles++;
        end
        check_value(test_name, "rate_out", value, int'(rate_out));
    endtask

    task automatic request_rate(input rate_pkg::gen_e gen);
        @(posedge RATE_CLK);
        rate_in <= gen;
        pma_tx_seen = 1'b0;
        pma_rx_seen = 1'b0;
    endtask

    // 0 TX rate done, 1 RX rate done, 2 PHY status
    task automatic send_event(input int idx);
        @(posedge RATE_CLK);
        case (idx)
            0:       txratedone <= 1'b1;
            1:       rxratedone <= 1'b1;
            default: phystatus  <= 1'b1;
        endcase
        @(posedge RATE_CLK);
        txratedone <= 1'b0;
        rxratedone <= 1'b0;
        phystatus  <= 1'b0;
    endtask

    task automatic test_reset_sequence();
        wait_done("reset");
        check_value("reset", "rate_out", 0, int'(rate_out));
        check_value("reset", "gen3", 0, int'(gen3));
        check_value("reset", "pclk_sel", 0, int'(pclk_sel));
        check_value("reset", "sysclksel", 0, int'(sysclksel));
        check_value("reset", "txpmareset", 0, int'(txpmareset));
        check_value("reset", "rxpmareset", 0, int'(rxpmareset));
        sample_cycle();
        check_true("reset", idle && !done, "idle did not follow a single done pulse");
    endtask

    task automatic test_gen1_to_gen2();
        request_rate(rate_pkg::GEN2);
        wait_rate_out("gen1_to_gen2", 1);
        send_event(0);
        send_event(1);
        send_event(2);
        wait_done("gen1_to_gen2");
        check_value("gen1_to_gen2", "rate_out", 1, int'(rate_out));
        check_value("gen1_to_gen2", "pclk_sel", 1, int'(pclk_sel));
        check_value("gen1_to_gen2", "gen3", 0, int'(gen3));
        check_value("gen1_to_gen2", "qpllpd", 1, int'(qpllpd));
        check_value("gen1_to_gen2", "cpllpd", 0, int'(cpllpd));
        check_value("gen1_to_gen2", "qpllreset", 1, int'(qpllreset));
        check_value("gen1_to_gen2", "cpllreset", 0, int'(cpllreset));
        check_true("gen1_to_gen2", !pma_tx_seen, "txpmareset rose during a Gen1/Gen2 change");
        sample_cycle();
    endtask

    task automatic test_completion_collect();
        int held;
        int first;
        int other;
        int i;
        bit early;
        held  = $urandom_range(2, 0);
        first = ($urandom_range(1, 0) == 1) ? (held + 1) % 3 : (held + 2) % 3;
        other = 3 - held - first;
        early = 1'b0;
        request_rate(rate_pkg::GEN1);
        wait_rate_out("collect", 0);
        send_event(first);
        repeat ($urandom_range(4, 1)) @(posedge RATE_CLK);
        send_event(other);
        for (i = 0; i < QUIET_CYCLES; i++)
        begin
            sample_cycle();
            if (done)
                early = 1'b1;
        end
        check_true("collect", !early, "done arrived while a completion event was missing");
        send_event(held);
        wait_done("collect");
        check_value("collect", "rate_out", 0, int'(rate_out));
        check_value("collect", "pclk_sel", 0, int'(pclk_sel));
        sample_cycle();
    endtask

    task automatic test_gen1_to_gen3();
        request_rate(rate_pkg::GEN3);
        wait_done("gen1_to_gen3");
        check_true("gen1_to_gen3", pma_tx_seen && pma_rx_seen,
                   "PMA resets were not held during Gen3 entry");
        check_value("gen1_to_gen3", "txpmareset", 0, int'(txpmareset));
        check_value("gen1_to_gen3", "rxpmareset", 0, int'(rxpmareset));
        check_value("gen1_to_gen3", "gen3", 1, int'(gen3));
        check_value("gen1_to_gen3", "sysclksel", 1, int'(sysclksel));
        check_value("gen1_to_gen3", "rate_out", 0, int'(rate_out));
        check_value("gen1_to_gen3", "cpllpd", 1, int'(cpllpd));
        check_value("gen1_to_gen3", "qpllpd", 0, int'(qpllpd));
        check_value("gen1_to_gen3", "cpllreset", 1, int'(cpllreset));
        check_value("gen1_to_gen3", "qpllreset", 0, int'(qpllreset));
        sample_cycle();
    endtask

    task automatic test_gen3_exit();
        request_rate(rate_pkg::GEN1);   // No completion events on exit
        wait_done("gen3_exit");
        check_value("gen3_exit", "gen3", 0, int'(gen3));
        check_value("gen3_exit", "pclk_sel", 0, int'(pclk_sel));
        check_value("gen3_exit", "sysclksel", 0, int'(sysclksel));
        check_value("gen3_exit", "qpllpd", 1, int'(qpllpd));
        sample_cycle();
    endtask

    task automatic test_inactive_lane();
        @(posedge RATE_CLK);
        active_lane <= 1'b0;
        request_rate(rate_pkg::GEN2);
        wait_done("inactive_lane");
        check_value("inactive_lane", "rate_out", 1, int'(rate_out));
        @(posedge RATE_CLK);
        active_lane <= 1'b1;
        sample_cycle();
    endtask

    initial
    begin
        void'($urandom(32'he43f));
        RATE_RST_N     = 1'b0;
        rst_idle       = 1'b0;
        active_lane    = 1'b1;
        rate_in        = rate_pkg::GEN1;
        cplllock       = 1'b1;
        qplllock       = 1'b1;
        mmcm_lock      = 1'b1;
        rxpmaresetdone = 1'b0;
        txratedone     = 1'b0;
        rxratedone     = 1'b0;
        phystatus      = 1'b0;
        repeat (RESET_CYCLES) @(posedge RATE_CLK);
        RATE_RST_N <= 1'b1;
        test_reset_sequence();
        @(posedge RATE_CLK);
        rst_idle <= 1'b1;   // Link leaves reset idle
        test_gen1_to_gen2();
        test_completion_collect();
        test_gen1_to_gen3();
        test_gen3_exit();
        test_inactive_lane();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: sources.f
hdl/rate_pkg.sv
hdl/rate_input_sync.sv
hdl/rate_done_tracker.sv
hdl/rate_sequencer.sv
hdl/pipe_rate.sv
tests/tb_pipe_rate.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_pipe_rate
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
